// ==== Bender.yml ====
package:
  name: stepper_motion

sources:
  - logic/stepper_pkg.sv
  - logic/spi_word.sv
  - logic/command_decoder.sv
  - logic/move_queue.sv
  - logic/dda_step_gen.sv
  - logic/hbridge_sequencer.sv
  - logic/quad_encoder.sv
  - logic/stepper_top.sv
  - target: test
    files:
      - test/stepper_tb.sv

// ==== logic/command_decoder.sv ====
`timescale 1ns/1ps

module command_decoder #(
  parameter int MOVE_BUFFER_BITS = 2
) (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic                    word_received,
  input  stepper_pkg::word_t      rx_word,
  input  stepper_pkg::count_t     position,
  output stepper_pkg::word_t      tx_word,
  output logic                    enable,
  output stepper_pkg::divisor_t   divisor,
  output stepper_pkg::step_mode_t step_mode,
  output logic                    push,
  output logic                    push_dir,
  output stepper_pkg::word_t      push_duration,
  output stepper_pkg::count_t     push_increment,
  output stepper_pkg::count_t     push_incinc,
  output logic                    led
);

  typedef enum logic [2:0] {
    header,
    move_duration,
    move_increment,
    move_incinc,
    reply_wait
  } state_t;

  state_t state;
  stepper_pkg::header_t code;

  assign code = rx_word[63:56];

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= header;
      enable <= 1'b0;
      divisor <= stepper_pkg::DEFAULT_DIVISOR;
      step_mode <= stepper_pkg::step_mode_t'(1);
      push <= 1'b0;
      led <= 1'b0;
      tx_word <= '0;
    end else begin
      push <= 1'b0;
      if (word_received) begin
        led <= !led;
        // Default reply is the encoder count
        tx_word <= position;
        case (state)
          header: begin
            case (code)
              stepper_pkg::CMD_COORDINATED_STEP: state <= move_duration;
              stepper_pkg::CMD_MOTOR_ENABLE: enable <= rx_word[0];
              stepper_pkg::CMD_CLK_DIVISOR: divisor <= rx_word[7:0];
              stepper_pkg::CMD_STEP_MODE: step_mode <= rx_word[2:0];
              stepper_pkg::CMD_API_VERSION: begin
                tx_word <= {40'd0, stepper_pkg::VERSION_MAJOR,
                            stepper_pkg::VERSION_MINOR, stepper_pkg::VERSION_PATCH};
                state <= reply_wait;
              end
              // Unknown headers fall through
              default: ;
            endcase
          end
          move_duration: state <= move_increment;
          move_increment: state <= move_incinc;
          // Record complete, hand it to the queue
          move_incinc: begin
            push <= 1'b1;
            state <= header;
          end
          // Dummy word carrying the version reply out
          default: state <= header;
        endcase
      end
    end
  end

  // Move fields assembled word by word
  always_ff @(posedge CLK) begin
    if (word_received) begin
      case (state)
        header: begin
          // Only bit 0 of the direction field is used
          if (code == stepper_pkg::CMD_COORDINATED_STEP) begin
            push_dir <= rx_word[0];
          end
        end
        move_duration: push_duration <= rx_word;
        move_increment: push_increment <= rx_word;
        move_incinc: push_incinc <= rx_word;
        default: ;
      endcase
    end
  end

endmodule

// ==== logic/dda_step_gen.sv ====
`timescale 1ns/1ps

module dda_step_gen (
  input  logic                  CLK,
  input  logic                  reset,
  input  stepper_pkg::divisor_t divisor,
  input  logic                  empty,
  input  logic                  head_dir,
  input  stepper_pkg::word_t    head_duration,
  input  stepper_pkg::count_t   head_increment,
  input  stepper_pkg::count_t   head_incinc,
  output logic                  pop,
  output logic                  step,
  output logic                  dir,
  output logic                  moving
);

  typedef enum logic {idle, running} state_t;

  state_t state;
  stepper_pkg::divisor_t div_count;
  stepper_pkg::word_t ticks_left;
  stepper_pkg::count_t move_increment;
  stepper_pkg::count_t move_incinc;
  stepper_pkg::count_t increment;
  stepper_pkg::count_t accumulator;
  stepper_pkg::count_t next_increment;
  stepper_pkg::count_t sum;
  logic move_dir;
  logic first_tick;
  logic tick;
  logic last_tick;

  // One tick every divisor CLK cycles
  assign tick = (state == running) && (div_count == divisor - 8'd1);
  // Duration 0 behaves as a single tick
  assign last_tick = tick && (ticks_left <= 64'd1);

  // Load from idle, or chain straight off the last tick
  assign pop = !empty && ((state == idle) || last_tick);

  // Second order: increment grows by incinc each tick
  assign next_increment = first_tick ? move_increment : increment + move_incinc;
  assign sum = accumulator + next_increment;

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= idle;
      div_count <= '0;
      ticks_left <= '0;
      first_tick <= 1'b0;
      accumulator <= '0;
      step <= 1'b0;
      dir <= 1'b0;
      moving <= 1'b0;
    end else begin
      step <= 1'b0;
      if (tick) begin
        div_count <= '0;
        ticks_left <= ticks_left - 64'd1;
        first_tick <= 1'b0;
        // Overflow past zero means one step
        if (sum > 0) begin
          step <= 1'b1;
          accumulator <= sum - stepper_pkg::STEP_THRESHOLD;
        end else begin
          accumulator <= sum;
        end
        // Direction travels with its own step strobe
        dir <= move_dir;
      end else if (state == running) begin
        div_count <= div_count + 8'd1;
      end
      // Load wins over the tick bookkeeping above
      if (pop) begin
        state <= running;
        moving <= 1'b1;
        div_count <= '0;
        ticks_left <= head_duration;
        first_tick <= 1'b1;
      end else if (last_tick) begin
        state <= idle;
        moving <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (pop) begin
      move_dir <= head_dir;
      move_increment <= head_increment;
      move_incinc <= head_incinc;
    end
    if (tick) begin
      increment <= next_increment;
    end
  end

endmodule

// ==== logic/hbridge_sequencer.sv ====
`timescale 1ns/1ps

module hbridge_sequencer (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic                    step,
  input  logic                    dir,
  input  logic                    enable,
  input  stepper_pkg::step_mode_t step_mode,
  output logic                    phase_a1,
  output logic                    phase_a2,
  output logic                    phase_b1,
  output logic                    phase_b2
);

  // Position in half steps, wraps every electrical cycle
  logic [2:0] index;
  logic [2:0] stride;
  logic [3:0] pattern;

  // Full step skips the in-between positions
  assign stride = (step_mode < 3'd2) ? 3'd2 : 3'd1;

  always_ff @(posedge CLK) begin
    if (reset) begin
      index <= '0;
    end else if (step) begin
      if (dir) begin
        index <= index + stride;
      end else begin
        index <= index - stride;
      end
    end
  end

  // Bit order a1 a2 b1 b2, a2 and b2 drive the reversed polarity
  always_comb begin
    case (index)
      3'd0: pattern = 4'b1000;
      3'd1: pattern = 4'b1010;
      3'd2: pattern = 4'b0010;
      3'd3: pattern = 4'b0110;
      3'd4: pattern = 4'b0100;
      3'd5: pattern = 4'b0101;
      3'd6: pattern = 4'b0001;
      default: pattern = 4'b1001;
    endcase
  end

  // Coils released when disabled, index kept
  assign {phase_a1, phase_a2, phase_b1, phase_b2} = enable ? pattern : 4'b0000;

endmodule

// ==== logic/move_queue.sv ====
`timescale 1ns/1ps

module move_queue #(
  parameter int MOVE_BUFFER_BITS = 2
) (
  input  logic                CLK,
  input  logic                reset,
  input  logic                push,
  input  logic                push_dir,
  input  stepper_pkg::word_t  push_duration,
  input  stepper_pkg::count_t push_increment,
  input  stepper_pkg::count_t push_incinc,
  input  logic                pop,
  output logic                head_dir,
  output stepper_pkg::word_t  head_duration,
  output stepper_pkg::count_t head_increment,
  output stepper_pkg::count_t head_incinc,
  output logic                full,
  output logic                empty
);

  localparam int unsigned DEPTH = 2 ** MOVE_BUFFER_BITS;

  logic dir_mem [DEPTH];
  stepper_pkg::word_t duration_mem [DEPTH];
  stepper_pkg::count_t increment_mem [DEPTH];
  stepper_pkg::count_t incinc_mem [DEPTH];

  // Extra MSB tells a wrapped writer from an empty queue
  logic [MOVE_BUFFER_BITS:0] wr_ptr;
  logic [MOVE_BUFFER_BITS:0] rd_ptr;
  logic do_push;
  logic do_pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[MOVE_BUFFER_BITS] != rd_ptr[MOVE_BUFFER_BITS]) &&
                (wr_ptr[MOVE_BUFFER_BITS-1:0] == rd_ptr[MOVE_BUFFER_BITS-1:0]);

  // Push into a full queue is dropped
  assign do_push = push && !full;
  assign do_pop = pop && !empty;

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      dir_mem[wr_ptr[MOVE_BUFFER_BITS-1:0]] <= push_dir;
      duration_mem[wr_ptr[MOVE_BUFFER_BITS-1:0]] <= push_duration;
      increment_mem[wr_ptr[MOVE_BUFFER_BITS-1:0]] <= push_increment;
      incinc_mem[wr_ptr[MOVE_BUFFER_BITS-1:0]] <= push_incinc;
    end
  end

  // Head record, valid while empty is low
  assign head_dir = dir_mem[rd_ptr[MOVE_BUFFER_BITS-1:0]];
  assign head_duration = duration_mem[rd_ptr[MOVE_BUFFER_BITS-1:0]];
  assign head_increment = increment_mem[rd_ptr[MOVE_BUFFER_BITS-1:0]];
  assign head_incinc = incinc_mem[rd_ptr[MOVE_BUFFER_BITS-1:0]];

endmodule

// ==== logic/quad_encoder.sv ====
`timescale 1ns/1ps

module quad_encoder (
  input  logic                CLK,
  input  logic                reset,
  input  logic                enc_a,
  input  logic                enc_b,
  output stepper_pkg::count_t position
);

  logic [1:0] a_pipe;
  logic [1:0] b_pipe;
  // Last accepted A/B pair
  logic [1:0] ab_prev;
  logic [1:0] ab_now;

  assign ab_now = {a_pipe[1], b_pipe[1]};

  always_ff @(posedge CLK) begin
    if (reset) begin
      a_pipe <= '0;
      b_pipe <= '0;
      ab_prev <= '0;
      position <= '0;
    end else begin
      a_pipe <= {a_pipe[0], enc_a};
      b_pipe <= {b_pipe[0], enc_b};
      ab_prev <= ab_now;
      case ({ab_prev, ab_now})
        // A leads B: 00 10 11 01
        4'b0010, 4'b1011, 4'b1101, 4'b0100: position <= position + 64'sd1;
        // B leads A
        4'b0001, 4'b0111, 4'b1110, 4'b1000: position <= position - 64'sd1;
        // No change, or both bits flipped
        default: ;
      endcase
    end
  end

endmodule

// ==== logic/spi_word.sv ====
`timescale 1ns/1ps

module spi_word (
  input  logic               CLK,
  input  logic               reset,
  input  logic               sck,
  input  logic               cs,
  input  logic               copi,
  output logic               cipo,
  input  stepper_pkg::word_t tx_word,
  output stepper_pkg::word_t rx_word,
  output logic               word_received
);

  // Two sync stages plus a history stage for edge detect
  logic [2:0] sck_pipe;
  logic [2:0] cs_pipe;
  logic [1:0] copi_pipe;
  logic sck_rise;
  logic sck_fall;
  logic cs_rise;
  logic cs_fall;
  logic selected;
  stepper_pkg::word_t rx_shift;
  stepper_pkg::word_t tx_shift;

  always_ff @(posedge CLK) begin
    if (reset) begin
      sck_pipe <= '0;
      // CS idles high
      cs_pipe <= '1;
      copi_pipe <= '0;
    end else begin
      sck_pipe <= {sck_pipe[1:0], sck};
      cs_pipe <= {cs_pipe[1:0], cs};
      copi_pipe <= {copi_pipe[0], copi};
    end
  end

  // Edges seen between stage 1 and stage 2
  assign sck_rise = sck_pipe[1] && !sck_pipe[2];
  assign sck_fall = !sck_pipe[1] && sck_pipe[2];
  assign cs_rise = cs_pipe[1] && !cs_pipe[2];
  assign cs_fall = !cs_pipe[1] && cs_pipe[2];
  assign selected = !cs_pipe[1];

  // Strobe lands 3 CLK after CS rises on the pin
  always_ff @(posedge CLK) begin
    if (reset) begin
      word_received <= 1'b0;
    end else begin
      word_received <= cs_rise;
    end
  end

  always_ff @(posedge CLK) begin
    // Mode 0, host samples on rising SCK
    if (selected && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_pipe[1]};
    end
    // Reply word captured as the transfer opens
    if (cs_fall) begin
      tx_shift <= tx_word;
    end else if (selected && sck_fall) begin
      tx_shift <= {tx_shift[62:0], 1'b0};
    end
    if (cs_rise) begin
      rx_word <= rx_shift;
    end
  end

  // MSB first
  assign cipo = tx_shift[63];

endmodule

// ==== logic/stepper_pkg.sv ====
package stepper_pkg;

  // One SPI transfer, also the width of every move field
  typedef logic [63:0] word_t;

  // Signed position and DDA arithmetic
  typedef logic signed [63:0] count_t;

  // Command header, top byte of the first word
  typedef logic [7:0] header_t;

  // CLK cycles per DDA tick
  typedef logic [7:0] divisor_t;

  // Step resolution select
  typedef logic [2:0] step_mode_t;

  // Header codes
  localparam header_t CMD_COORDINATED_STEP = 8'd1;
  localparam header_t CMD_MOTOR_ENABLE = 8'd10;
  localparam header_t CMD_CLK_DIVISOR = 8'd20;
  localparam header_t CMD_STEP_MODE = 8'd30;
  localparam header_t CMD_API_VERSION = 8'd254;

  // Reported in the API reply, patch in the low byte
  localparam logic [7:0] VERSION_MAJOR = 8'd0;
  localparam logic [7:0] VERSION_MINOR = 8'd1;
  localparam logic [7:0] VERSION_PATCH = 8'd0;

  // Taken off the accumulator on each step
  // Just under the signed maximum, leaves headroom for one increment
  localparam count_t STEP_THRESHOLD = 64'h7fffffffffffff9b;

  // 400 kHz tick at a 16 MHz CLK
  localparam divisor_t DEFAULT_DIVISOR = 8'd40;

endpackage

// ==== logic/stepper_top.sv ====
`timescale 1ns/1ps

module stepper_top #(
  parameter int MOVE_BUFFER_BITS = 2
) (
  input  logic CLK,
  input  logic reset,
  input  logic sck,
  input  logic cs,
  input  logic copi,
  input  logic enc_a,
  input  logic enc_b,
  output logic cipo,
  output logic led,
  output logic moving,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2
);

  // SPI word path
  stepper_pkg::word_t tx_word;
  stepper_pkg::word_t rx_word;
  logic word_received;

  // Settings and encoder count
  stepper_pkg::count_t position;
  logic enable;
  stepper_pkg::divisor_t divisor;
  stepper_pkg::step_mode_t step_mode;

  // Move records into and out of the queue
  logic push;
  logic push_dir;
  stepper_pkg::word_t push_duration;
  stepper_pkg::count_t push_increment;
  stepper_pkg::count_t push_incinc;
  logic pop;
  logic empty;
  logic head_dir;
  stepper_pkg::word_t head_duration;
  stepper_pkg::count_t head_increment;
  stepper_pkg::count_t head_incinc;

  // Step strobe to the bridge
  logic step;
  logic dir;

  spi_word spi_word_i (
    .CLK(CLK),
    .reset(reset),
    .sck(sck),
    .cs(cs),
    .copi(copi),
    .cipo(cipo),
    .tx_word(tx_word),
    .rx_word(rx_word),
    .word_received(word_received)
  );

  command_decoder #(
    .MOVE_BUFFER_BITS(MOVE_BUFFER_BITS)
  ) command_decoder_i (
    .CLK(CLK),
    .reset(reset),
    .word_received(word_received),
    .rx_word(rx_word),
    .position(position),
    .tx_word(tx_word),
    .enable(enable),
    .divisor(divisor),
    .step_mode(step_mode),
    .push(push),
    .push_dir(push_dir),
    .push_duration(push_duration),
    .push_increment(push_increment),
    .push_incinc(push_incinc),
    .led(led)
  );

  // Full only drops pushes inside the queue
  move_queue #(
    .MOVE_BUFFER_BITS(MOVE_BUFFER_BITS)
  ) move_queue_i (
    .CLK(CLK),
    .reset(reset),
    .push(push),
    .push_dir(push_dir),
    .push_duration(push_duration),
    .push_increment(push_increment),
    .push_incinc(push_incinc),
    .pop(pop),
    .head_dir(head_dir),
    .head_duration(head_duration),
    .head_increment(head_increment),
    .head_incinc(head_incinc),
    .full(),
    .empty(empty)
  );

  dda_step_gen dda_step_gen_i (
    .CLK(CLK),
    .reset(reset),
    .divisor(divisor),
    .empty(empty),
    .head_dir(head_dir),
    .head_duration(head_duration),
    .head_increment(head_increment),
    .head_incinc(head_incinc),
    .pop(pop),
    .step(step),
    .dir(dir),
    .moving(moving)
  );

  hbridge_sequencer hbridge_sequencer_i (
    .CLK(CLK),
    .reset(reset),
    .step(step),
    .dir(dir),
    .enable(enable),
    .step_mode(step_mode),
    .phase_a1(phase_a1),
    .phase_a2(phase_a2),
    .phase_b1(phase_b1),
    .phase_b2(phase_b2)
  );

  quad_encoder quad_encoder_i (
    .CLK(CLK),
    .reset(reset),
    .enc_a(enc_a),
    .enc_b(enc_b),
    .position(position)
  );

endmodule

// ==== tb.f ====
logic/stepper_pkg.sv
logic/spi_word.sv
logic/command_decoder.sv
logic/move_queue.sv
logic/dda_step_gen.sv
logic/hbridge_sequencer.sv
logic/quad_encoder.sv
logic/stepper_top.sv
test/stepper_tb.sv

// ==== test/stepper_tb.sv ====
`timescale 1ns/1ps

module stepper_tb;

  localparam int ENTRIES = 10;
  localparam int KIND_RESET = 0;
  localparam int KIND_VERSION = 1;
  localparam int KIND_ENCODER = 2;
  localparam int KIND_SETTING = 3;
  localparam int KIND_MOVES = 4;
  localparam int ACK_TIMEOUT = 20;
  localparam int MOVE_TIMEOUT = 100000;

  logic CLK = 1'b0;
  logic reset;
  logic sck;
  logic cs;
  logic copi;
  logic enc_a;
  logic enc_b;
  logic cipo;
  logic led;
  logic moving;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;

  // Stimulus table, one column per field
  string tname [ENTRIES];
  int kind [ENTRIES];
  stepper_pkg::word_t cmd [ENTRIES];
  int arg_a [ENTRIES];
  int arg_b [ENTRIES];
  logic en_after [ENTRIES];
  logic [2:0] stride_after [ENTRIES];
  stepper_pkg::word_t expected [ENTRIES];

  // Reference model state
  logic [31:0] lfsr_state;
  stepper_pkg::count_t model_acc;
  logic [2:0] model_index;
  logic [2:0] model_stride;
  logic model_enable;
  logic [1:0] enc_phase;
  int words_sent;

  stepper_top #(
    .MOVE_BUFFER_BITS(2)
  ) dut_i (
    .CLK(CLK),
    .reset(reset),
    .sck(sck),
    .cs(cs),
    .copi(copi),
    .enc_a(enc_a),
    .enc_b(enc_b),
    .cipo(cipo),
    .led(led),
    .moving(moving),
    .phase_a1(phase_a1),
    .phase_a2(phase_a2),
    .phase_b1(phase_b1),
    .phase_b2(phase_b2)
  );

  // 8 ns period
  always #4 CLK = ~CLK;

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input stepper_pkg::word_t exp_value,
                            input stepper_pkg::word_t act_value);
    if (act_value !== exp_value) begin
      report_error($sformatf("Fail %s expected %h actual %h", name, exp_value, act_value));
    end
  endtask

  task automatic check_count(input string name, input stepper_pkg::count_t exp_value,
                             input stepper_pkg::count_t act_value);
    if (act_value !== exp_value) begin
      report_error($sformatf("Fail %s expected %0d actual %0d", name, exp_value, act_value));
    end
  endtask

  task automatic check_phases(input string name, input logic [3:0] exp_value,
                              input logic [3:0] act_value);
    if (act_value !== exp_value) begin
      report_error($sformatf("Fail %s expected %b actual %b", name, exp_value, act_value));
    end
  endtask

  task automatic check_level(input string name, input logic exp_value, input logic act_value);
    if (act_value !== exp_value) begin
      report_error($sformatf("Fail %s expected %b actual %b", name, exp_value, act_value));
    end
  endtask

  // Galois LFSR, right shifting
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'ha3000000) : (state >> 1);
  endfunction

  // One LFSR step per bit
  function automatic stepper_pkg::word_t take_bits(input int n);
    stepper_pkg::word_t value;
    int k;
    value = '0;
    for (k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[62:0], lfsr_state[0]};
    end
    return value;
  endfunction

  // Half-step table A, AB, B, BA', A', A'B', B', B'A as a1 a2 b1 b2
  function automatic logic [3:0] expected_phases(input logic [2:0] index, input logic enable);
    logic [3:0] pattern;
    case (index)
      3'd0: pattern = 4'b1000;
      3'd1: pattern = 4'b1010;
      3'd2: pattern = 4'b0010;
      3'd3: pattern = 4'b0110;
      3'd4: pattern = 4'b0100;
      3'd5: pattern = 4'b0101;
      3'd6: pattern = 4'b0001;
      default: pattern = 4'b1001;
    endcase
    return enable ? pattern : 4'b0000;
  endfunction

  // A leads B when walking up
  function automatic logic [1:0] gray_code(input logic [1:0] idx);
    case (idx)
      2'd0: return 2'b00;
      2'd1: return 2'b10;
      2'd2: return 2'b11;
      default: return 2'b01;
    endcase
  endfunction

  // Mode 0 host, SCK is CLK/8, MSB first
  task automatic spi_exchange(input stepper_pkg::word_t tx, output stepper_pkg::word_t rx);
    stepper_pkg::word_t shifted;
    logic led_before;
    int i;
    int cycles;
    led_before = led;
    shifted = '0;
    cs = 1'b0;
    repeat (4) @(negedge CLK);
    for (i = 63; i >= 0; i--) begin
      copi = tx[i];
      repeat (4) @(negedge CLK);
      shifted[i] = cipo;
      sck = 1'b1;
      repeat (4) @(negedge CLK);
      sck = 1'b0;
    end
    repeat (4) @(negedge CLK);
    cs = 1'b1;
    // led flips once the decoder has taken the word
    cycles = 0;
    while (led === led_before) begin
      @(negedge CLK);
      cycles++;
      if (cycles > ACK_TIMEOUT) report_error("SPI word was never taken, led did not toggle");
    end
    words_sent++;
    check_level("led_per_word", logic'(words_sent % 2), led);
    rx = shifted;
  endtask

  task automatic drive_encoder(input int edges, input logic forward);
    int k;
    for (k = 0; k < edges; k++) begin
      enc_phase = forward ? enc_phase + 2'd1 : enc_phase - 2'd1;
      {enc_a, enc_b} = gray_code(enc_phase);
      // Count settles 3 CLK after the edge
      repeat (4) @(negedge CLK);
    end
  endtask

  task automatic wait_moving(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (moving !== level) begin
      @(negedge CLK);
      cycles++;
      if (cycles > MOVE_TIMEOUT) report_error(what);
    end
  endtask

  // DDA reference, accumulator carried from move to move
  task automatic model_move(input logic dir, input stepper_pkg::word_t duration,
                            input stepper_pkg::count_t increment,
                            input stepper_pkg::count_t incinc);
    stepper_pkg::count_t inc;
    stepper_pkg::count_t sum;
    stepper_pkg::word_t t;
    inc = increment;
    for (t = 0; t < duration; t++) begin
      if (t != 0) inc = inc + incinc;
      sum = model_acc + inc;
      if (sum > 0) begin
        model_acc = sum - stepper_pkg::STEP_THRESHOLD;
        model_index = dir ? model_index + model_stride : model_index - model_stride;
      end else begin
        model_acc = sum;
      end
    end
  endtask

  // Later moves alternate direction and are queued while the first runs
  task automatic run_moves(input string name, input int n, input int first_duration);
    stepper_pkg::word_t rx;
    stepper_pkg::word_t duration;
    stepper_pkg::count_t increment;
    stepper_pkg::count_t incinc;
    logic dir;
    logic first_dir;
    int m;
    first_dir = logic'(take_bits(1));
    for (m = 0; m < n; m++) begin
      dir = first_dir ^ m[0];
      duration = (m == 0) ? first_duration + take_bits(6) : 64'd16 + take_bits(6);
      increment = take_bits(62);
      incinc = take_bits(40);
      model_move(dir, duration, increment, incinc);
      spi_exchange({stepper_pkg::CMD_COORDINATED_STEP, 55'd0, dir}, rx);
      spi_exchange(duration, rx);
      spi_exchange(increment, rx);
      spi_exchange(incinc, rx);
      wait_moving(1'b1, "moving never rose after a move was queued");
    end
    wait_moving(1'b0, "moving never fell after the queued moves");
    // Bridge follows the last step one cycle later
    repeat (2) @(negedge CLK);
    check_phases(name, expected_phases(model_index, model_enable),
                 {phase_a1, phase_a2, phase_b1, phase_b2});
  endtask

  task automatic add_entry(input int idx, input string name, input int k,
                           input stepper_pkg::word_t command, input int a, input int b,
                           input logic en, input logic [2:0] stride,
                           input stepper_pkg::word_t exp_value);
    tname[idx] = name;
    kind[idx] = k;
    cmd[idx] = command;
    arg_a[idx] = a;
    arg_b[idx] = b;
    en_after[idx] = en;
    stride_after[idx] = stride;
    expected[idx] = exp_value;
  endtask

  task automatic load_table();
    add_entry(0, "reset_state", KIND_RESET, '0, 0, 0, 1'b0, 3'd2, '0);
    // Patch, minor, major from byte 0 up
    add_entry(1, "api_version", KIND_VERSION, {stepper_pkg::CMD_API_VERSION, 56'd0}, 0, 0,
              1'b0, 3'd2, {40'd0, stepper_pkg::VERSION_MAJOR, stepper_pkg::VERSION_MINOR,
              stepper_pkg::VERSION_PATCH});
    // 6 edges forward, 9 back
    add_entry(2, "encoder_count", KIND_ENCODER, '0, 6, 9, 1'b0, 3'd2, '0);
    add_entry(3, "motor_enable", KIND_SETTING, {stepper_pkg::CMD_MOTOR_ENABLE, 55'd0, 1'b1},
              0, 0, 1'b1, 3'd2, '0);
    add_entry(4, "full_step_move", KIND_MOVES, '0, 1, 16, 1'b1, 3'd2, '0);
    add_entry(5, "half_step_mode", KIND_SETTING, {stepper_pkg::CMD_STEP_MODE, 53'd0, 3'd2},
              0, 0, 1'b1, 3'd1, '0);
    add_entry(6, "clock_divisor", KIND_SETTING, {stepper_pkg::CMD_CLK_DIVISOR, 48'd0, 8'd12},
              0, 0, 1'b1, 3'd1, '0);
    // First move long enough to cover sending the second
    add_entry(7, "back_to_back_moves", KIND_MOVES, '0, 2, 400, 1'b1, 3'd1, '0);
    add_entry(8, "motor_disable", KIND_SETTING, {stepper_pkg::CMD_MOTOR_ENABLE, 56'd0},
              0, 0, 1'b0, 3'd1, '0);
    add_entry(9, "motor_re_enable", KIND_SETTING, {stepper_pkg::CMD_MOTOR_ENABLE, 55'd0, 1'b1},
              0, 0, 1'b1, 3'd1, '0);
  endtask

  initial begin
    stepper_pkg::word_t rx;
    int i;
    reset = 1'b1;
    sck = 1'b0;
    cs = 1'b1;
    copi = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    lfsr_state = 32'h1fbe;
    model_acc = '0;
    model_index = '0;
    model_stride = 3'd2;
    model_enable = 1'b0;
    enc_phase = '0;
    words_sent = 0;
    load_table();
    repeat (2) @(negedge CLK);
    reset = 1'b0;
    for (i = 0; i < ENTRIES; i++) begin
      model_enable = en_after[i];
      model_stride = stride_after[i];
      case (kind[i])
        KIND_RESET: begin
          check_phases(tname[i], 4'b0000, {phase_a1, phase_a2, phase_b1, phase_b2});
          check_level("moving_after_reset", 1'b0, moving);
          check_level("led_after_reset", 1'b0, led);
        end
        KIND_VERSION: begin
          spi_exchange(cmd[i], rx);
          // Reply rides out on the dummy word
          spi_exchange('0, rx);
          check_word(tname[i], expected[i], rx);
        end
        KIND_ENCODER: begin
          drive_encoder(arg_a[i], 1'b1);
          drive_encoder(arg_b[i], 1'b0);
          // First word latches the count, second carries it back
          spi_exchange('0, rx);
          spi_exchange('0, rx);
          check_count(tname[i], stepper_pkg::count_t'(arg_a[i] - arg_b[i]), rx);
        end
        KIND_SETTING: begin
          spi_exchange(cmd[i], rx);
          check_phases(tname[i], expected_phases(model_index, model_enable),
                       {phase_a1, phase_a2, phase_b1, phase_b2});
        end
        default: run_moves(tname[i], arg_a[i], arg_b[i]);
      endcase
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
